/* Bender.yml */
package:
  name: dma_ctrl

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dma_pkg.sv
      - src/dma_axi_ingress.sv
      - src/dma_cmd_buffer.sv
      - src/dma_mem_issue.sv
      - src/dma_ctrl.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/dma_ctrl_tb.sv

/* dma_ctrl.f */
+incdir+src
src/dma_pkg.sv
src/dma_axi_ingress.sv
src/dma_cmd_buffer.sv
src/dma_mem_issue.sv
src/dma_ctrl.sv
test/dma_ctrl_tb.sv

/* src/dma_axi_ingress.sv */
// AXI write and read holding buffers, alternating channel arbiter and command hand-off
`default_nettype none
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_axi_ingress
   import dma_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     aw_valid,
   input  axi_aw_t  aw,
   output logic     aw_ready,
   input  logic     w_valid,
   input  axi_w_t   w,
   output logic     w_ready,
   input  logic     ar_valid,
   input  axi_ar_t  ar,
   output logic     ar_ready,
   output logic     cmd_valid,
   output bus_cmd_t cmd,
   input  logic     cmd_ready
);

   axi_aw_t aw_q;
   axi_w_t  w_q;
   axi_ar_t ar_q;
   logic    aw_vld;
   logic    w_vld;
   logic    ar_vld;
   logic    wr_pri;      // 1 -> write wins a tie
   logic    aw_take;
   logic    w_take;
   logic    ar_take;
   logic    wr_full;
   logic    sel_wr;
   logic    cmd_sent;
   logic    wr_sent;
   logic    rd_sent;

   //*************************************************************************
   // Channel handshakes and holding buffers
   //*************************************************************************
   assign aw_take = aw_valid & aw_ready;
   assign w_take  = w_valid & w_ready;
   assign ar_take = ar_valid & ar_ready;

   // Buffer is free again in the cycle its command leaves
   assign aw_ready = ~(aw_vld & ~wr_sent);
   assign w_ready  = ~(w_vld & ~wr_sent);
   assign ar_ready = ~(ar_vld & ~rd_sent);

   always_ff @(posedge clk) begin
      if (reset) begin
         aw_vld <= 1'b0;
         w_vld  <= 1'b0;
         ar_vld <= 1'b0;
         wr_pri <= 1'b0;      // Read side first
      end else begin
         aw_vld <= aw_take | (aw_vld & ~wr_sent);
         w_vld  <= w_take | (w_vld & ~wr_sent);
         ar_vld <= ar_take | (ar_vld & ~rd_sent);
         if (cmd_sent) begin
            wr_pri <= ~wr_pri;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_take) begin
         aw_q <= aw;
      end
      if (w_take) begin
         w_q <= w;
      end
      if (ar_take) begin
         ar_q <= ar;
      end
   end

   //*************************************************************************
   // Arbitration between a complete write and a read
   //*************************************************************************
   assign wr_full   = aw_vld & w_vld;
   assign sel_wr    = (wr_full & ar_vld) ? wr_pri : wr_full;
   assign cmd_valid = wr_full | ar_vld;
   assign cmd_sent  = cmd_valid & cmd_ready;
   assign wr_sent   = cmd_sent & sel_wr;
   assign rd_sent   = cmd_sent & ~sel_wr;

   always_comb begin
      cmd.write = sel_wr;
      cmd.addr  = sel_wr ? aw_q.addr : ar_q.addr;
      cmd.size  = sel_wr ? aw_q.size : ar_q.size;
      cmd.data  = w_q.data;
      cmd.strb  = w_q.strb;
      cmd.tag   = sel_wr ? aw_q.id : ar_q.id;
   end

   // A command only appears after a channel delivered a beat on the edge before
   a_cmd_from_channel: assert property (@(posedge clk) disable iff (reset)
      $rose(cmd_valid) |-> $past(aw_take | w_take | ar_take));

endmodule

`default_nettype wire

/* src/dma_cmd_buffer.sv */
// Circular DMA command buffer with issue and response pointers and B/R response outputs
`default_nettype none
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_cmd_buffer
   import dma_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     cmd_valid,
   input  bus_cmd_t cmd,
   output logic     cmd_ready,
   output head_t    head,
   output data_t    wdata,        // Write data of the head entry
   output ptr_t     issue_ptr,
   input  logic     issue_fire,
   input  logic     issue_err,
   input  resp_t    err_resp,
   input  mem_rsp_t mem_rsp,
   output logic     b_valid,
   output axi_b_t   b,
   input  logic     b_ready,
   output logic     r_valid,
   output axi_r_t   r,
   input  logic     r_ready,
   output logic     active
);

   localparam int DEPTH = `DMA_BUF_DEPTH;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DEPTH-1:0] e_valid;
   logic [DEPTH-1:0] e_pend;     // Read sent, data outstanding
   logic [DEPTH-1:0] e_done;
   logic [DEPTH-1:0] e_write;
   resp_t            e_err  [DEPTH];
   addr_t            e_addr [DEPTH];
   size_t            e_size [DEPTH];
   strb_t            e_strb [DEPTH];
   tag_t             e_tag  [DEPTH];
   data_t            e_data [DEPTH];

   ptr_t             wr_ptr;
   ptr_t             rsp_ptr;
   logic [CNT_W-1:0] count;
   logic             cmd_take;
   logic             rsp_valid;
   logic             rsp_sent;

   function automatic ptr_t ptr_inc(input ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign cmd_ready = (count != CNT_W'(DEPTH));
   assign cmd_take  = cmd_valid & cmd_ready;

   //*************************************************************************
   // Entry status and pointers
   //*************************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         e_valid   <= '0;
         e_pend    <= '0;
         e_done    <= '0;
         wr_ptr    <= '0;
         issue_ptr <= '0;
         rsp_ptr   <= '0;
         count     <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (cmd_take && wr_ptr == ptr_t'(i)) begin
               e_valid[i] <= 1'b1;
               e_pend[i]  <= 1'b0;
               e_done[i]  <= 1'b0;
            end
            // Writes and errors finish at issue, reads wait for the return
            if ((issue_fire || issue_err) && issue_ptr == ptr_t'(i)) begin
               e_pend[i] <= issue_fire & ~e_write[i];
               e_done[i] <= issue_err | e_write[i];
            end
            if (mem_rsp.rvalid && mem_rsp.rtag == ptr_t'(i)) begin
               e_done[i] <= 1'b1;
            end
            if (rsp_sent && rsp_ptr == ptr_t'(i)) begin
               e_valid[i] <= 1'b0;
               e_pend[i]  <= 1'b0;
               e_done[i]  <= 1'b0;
            end
         end
         if (cmd_take) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (issue_fire || issue_err) begin
            issue_ptr <= ptr_inc(issue_ptr);
         end
         if (rsp_sent) begin
            rsp_ptr <= ptr_inc(rsp_ptr);
         end
         case ({cmd_take, rsp_sent})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   //*************************************************************************
   // Entry payload
   //*************************************************************************
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (cmd_take && wr_ptr == ptr_t'(i)) begin
            e_write[i] <= cmd.write;
            e_addr[i]  <= cmd.addr;
            e_size[i]  <= cmd.size;
            e_strb[i]  <= cmd.strb;
            e_tag[i]   <= cmd.tag;
            e_data[i]  <= cmd.data;
            e_err[i]   <= `RESP_OKAY;
         end
         // Failed commands report their address as data
         if (issue_err && issue_ptr == ptr_t'(i)) begin
            e_err[i]  <= err_resp;
            e_data[i] <= data_t'(e_addr[i]);
         end
         if (mem_rsp.rvalid && mem_rsp.rtag == ptr_t'(i)) begin
            e_err[i]  <= mem_rsp.ecc_error ? `RESP_SLVERR : `RESP_OKAY;
            e_data[i] <= mem_rsp.ecc_error ? data_t'(e_addr[i]) : mem_rsp.rdata;
         end
      end
   end

   // Head entry toward the DCCM issue logic
   always_comb begin
      head.valid   = e_valid[issue_ptr];
      head.pending = e_pend[issue_ptr];
      head.done    = e_done[issue_ptr];
      head.addr    = e_addr[issue_ptr];
      head.size    = e_size[issue_ptr];
      head.write   = e_write[issue_ptr];
      head.strb    = e_strb[issue_ptr];
   end
   assign wdata = e_data[issue_ptr];

   //*************************************************************************
   // Responses in arrival order
   //*************************************************************************
   assign rsp_valid = e_valid[rsp_ptr] & e_done[rsp_ptr];
   assign b_valid   = rsp_valid & e_write[rsp_ptr];
   assign r_valid   = rsp_valid & ~e_write[rsp_ptr];
   assign rsp_sent  = (b_valid & b_ready) | (r_valid & r_ready);
   assign active    = |e_valid;

   always_comb begin
      b.id   = e_tag[rsp_ptr];
      b.resp = e_err[rsp_ptr];
      r.id   = e_tag[rsp_ptr];
      r.data = e_data[rsp_ptr];
      r.resp = e_err[rsp_ptr];
   end

   a_done_valid: assert property (@(posedge clk) disable iff (reset)
      (e_done & ~e_valid) == '0);

   // DCCM returns only target reads still in flight
   a_rsp_pending: assert property (@(posedge clk) disable iff (reset)
      mem_rsp.rvalid |-> e_pend[mem_rsp.rtag] && !e_done[mem_rsp.rtag]);

   a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
      (b_valid && !b_ready) || (r_valid && !r_ready) |=> $stable({b_valid, r_valid, b, r}));

endmodule

`default_nettype wire

/* src/dma_ctrl.sv */
// DMA slave controller top level with AXI ingress, command buffer and DCCM issue
`default_nettype none
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_ctrl
   import dma_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   // AXI slave channels
   input  logic     aw_valid,
   input  axi_aw_t  aw,
   output logic     aw_ready,
   input  logic     w_valid,
   input  axi_w_t   w,
   output logic     w_ready,
   input  logic     ar_valid,
   input  axi_ar_t  ar,
   output logic     ar_ready,
   output logic     b_valid,
   output axi_b_t   b,
   input  logic     b_ready,
   output logic     r_valid,
   output axi_r_t   r,
   input  logic     r_ready,
   // DCCM port
   output logic     dccm_req,
   output mem_req_t dccm_req_data,
   input  logic     dccm_ready,
   input  mem_rsp_t dccm_rsp,
   output logic     dma_active
);

   logic     cmd_valid;
   bus_cmd_t cmd;
   logic     cmd_ready;
   head_t    head;
   data_t    head_wdata;
   ptr_t     issue_ptr;
   logic     issue_fire;
   logic     issue_err;
   resp_t    err_resp;

   dma_axi_ingress u_ingress (
      .clk       (clk),
      .reset     (reset),
      .aw_valid  (aw_valid),
      .aw        (aw),
      .aw_ready  (aw_ready),
      .w_valid   (w_valid),
      .w         (w),
      .w_ready   (w_ready),
      .ar_valid  (ar_valid),
      .ar        (ar),
      .ar_ready  (ar_ready),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_ready (cmd_ready)
   );

   dma_cmd_buffer u_cmd_buf (
      .clk        (clk),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_ready  (cmd_ready),
      .head       (head),
      .wdata      (head_wdata),
      .issue_ptr  (issue_ptr),
      .issue_fire (issue_fire),
      .issue_err  (issue_err),
      .err_resp   (err_resp),
      .mem_rsp    (dccm_rsp),
      .b_valid    (b_valid),
      .b          (b),
      .b_ready    (b_ready),
      .r_valid    (r_valid),
      .r          (r),
      .r_ready    (r_ready),
      .active     (dma_active)
   );

   dma_mem_issue u_issue (
      .head       (head),
      .issue_ptr  (issue_ptr),
      .wdata      (head_wdata),
      .dccm_ready (dccm_ready),
      .dccm_req   (dccm_req),
      .req        (dccm_req_data),
      .issue_fire (issue_fire),
      .issue_err  (issue_err),
      .err_resp   (err_resp)
   );

endmodule

`default_nettype wire

/* src/dma_mem_issue.sv */
// DCCM range and access legality checks and DCCM request formation for the head entry
`default_nettype none
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_mem_issue
   import dma_pkg::*;
(
   input  head_t    head,
   input  ptr_t     issue_ptr,
   input  data_t    wdata,
   input  logic     dccm_ready,
   output logic     dccm_req,
   output mem_req_t req,
   output logic     issue_fire,
   output logic     issue_err,
   output resp_t    err_resp
);

   localparam addr_t DCCM_MASK = ~addr_t'(`DCCM_SIZE - 1);

   logic       req_spec;
   logic       in_dccm;
   logic       addr_err;
   logic       misalign;
   logic       wr_size_err;
   logic       strb_err;
   logic       align_err;
   logic [3:0] word_strb;
   logic       half_wr;      // Doubleword write using one word only

   assign req_spec = head.valid & ~head.pending & ~head.done;
   assign in_dccm  = (head.addr & DCCM_MASK) == addr_t'(`DCCM_SADR);
   assign addr_err = req_spec & ~in_dccm;

   //*************************************************************************
   // Size and strobe legality
   //*************************************************************************
   assign misalign = ((head.size == 3'd1) & head.addr[0]) |
                     ((head.size == 3'd2) & (|head.addr[1:0])) |
                     ((head.size == 3'd3) & (|head.addr[2:0])) |
                     (head.size > 3'd3);
   assign wr_size_err = head.write & (head.size < 3'd2);     // Sub-word writes
   assign word_strb   = head.addr[2] ? head.strb[7:4] : head.strb[3:0];
   assign strb_err    = head.write &
                        (((head.size == 3'd2) & (word_strb != 4'hF)) |
                         ((head.size == 3'd3) & ~((head.strb == 8'h0F) | (head.strb == 8'hF0) |
                                                   (head.strb == 8'hFF))));
   assign align_err = req_spec & in_dccm & (misalign | wr_size_err | strb_err);

   assign issue_err = addr_err | align_err;
   assign err_resp  = addr_err ? `RESP_DECERR : `RESP_SLVERR;

   //*************************************************************************
   // DCCM request
   //*************************************************************************
   assign dccm_req   = req_spec & ~issue_err & dccm_ready;
   assign issue_fire = dccm_req;
   assign half_wr    = head.write & ((head.strb == 8'h0F) | (head.strb == 8'hF0));

   always_comb begin
      req.addr  = head.addr;
      if (head.write && head.strb == 8'hF0) begin
         req.addr[2] = 1'b1;   // Upper word
      end
      req.size  = half_wr ? 3'd2 : head.size;
      req.write = head.write;
      req.wdata = wdata;
      req.tag   = issue_ptr;
   end

endmodule

`default_nettype wire

/* src/dma_pkg.sv */
// Vector types and packed structs for the AXI channels, commands and DCCM traffic
`default_nettype none
`include "dma_settings.svh"

package dma_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;
   typedef logic [2:0]  size_t;   // log2 of bytes
   typedef logic [`DMA_BUS_TAG-1:0] tag_t;
   typedef logic [$clog2(`DMA_BUF_DEPTH)-1:0] ptr_t;
   typedef logic [1:0]  resp_t;

   //*************************************************************************
   // AXI channel payloads
   //*************************************************************************
   typedef struct packed {
      tag_t  id;
      addr_t addr;
      size_t size;
   } axi_aw_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
   } axi_w_t;

   typedef struct packed {
      tag_t  id;
      addr_t addr;
      size_t size;
   } axi_ar_t;

   typedef struct packed {
      tag_t  id;
      resp_t resp;
   } axi_b_t;

   typedef struct packed {
      tag_t  id;
      data_t data;
      resp_t resp;
   } axi_r_t;

   // Granted command from the ingress arbiter
   typedef struct packed {
      logic  write;
      addr_t addr;
      size_t size;
      data_t data;
      strb_t strb;
      tag_t  tag;
   } bus_cmd_t;

   //*************************************************************************
   // DCCM side
   //*************************************************************************
   typedef struct packed {
      addr_t addr;
      size_t size;
      logic  write;
      data_t wdata;
      ptr_t  tag;      // Buffer entry of the request
   } mem_req_t;

   typedef struct packed {
      logic  rvalid;
      logic  ecc_error;
      ptr_t  rtag;
      data_t rdata;
   } mem_rsp_t;

   // Entry at the issue pointer
   typedef struct packed {
      logic  valid;
      logic  pending;
      logic  done;
      addr_t addr;
      size_t size;
      logic  write;
      strb_t strb;
   } head_t;

endpackage

`default_nettype wire

/* src/dma_settings.svh */
// Command buffer depth, bus tag width, DCCM address window and AXI response codes
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

//****************************************************************************
// Command buffer
//****************************************************************************
`define DMA_BUF_DEPTH 5
// Width of the master transaction ID
`define DMA_BUS_TAG 4

//****************************************************************************
// DCCM window, size is a power of two in bytes
//****************************************************************************
`define DCCM_SADR 32'hF004_0000
`define DCCM_SIZE 32'h0001_0000

//****************************************************************************
// Response codes on B and R
//****************************************************************************
`define RESP_OKAY 2'b00
`define RESP_SLVERR 2'b10
`define RESP_DECERR 2'b11

`endif

/* test/dma_ctrl_tb.sv */
// Testbench with clock, reset, DCCM model, value check, directed tests and timeout
`default_nettype none
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_ctrl_tb
   import dma_pkg::*;
();

   localparam addr_t SADR     = `DCCM_SADR;
   localparam addr_t ECC_ADDR = `DCCM_SADR + 32'h180;   // Reads here return an ECC error
   localparam int    BP_CMDS  = `DMA_BUF_DEPTH + 2;
   // Rough cycle budget per test
   localparam int LEN_RESET = 12;
   localparam int LEN_ROUND = 30;
   localparam int LEN_NARROW = 100;
   localparam int LEN_DECODE = 45;
   localparam int LEN_ALIGN = 45;
   localparam int LEN_ECC = 30;
   localparam int LEN_BACKP = 130;
   localparam int TIMEOUT_CYCLES = 4 * (LEN_RESET + LEN_ROUND + LEN_NARROW + LEN_DECODE +
                                        LEN_ALIGN + LEN_ECC + LEN_BACKP);

   logic     clk;
   logic     reset;
   logic     aw_valid;
   axi_aw_t  aw;
   logic     aw_ready;
   logic     w_valid;
   axi_w_t   w;
   logic     w_ready;
   logic     ar_valid;
   axi_ar_t  ar;
   logic     ar_ready;
   logic     b_valid;
   axi_b_t   b;
   logic     b_ready;
   logic     r_valid;
   axi_r_t   r;
   logic     r_ready;
   logic     dccm_req;
   mem_req_t dccm_req_data;
   logic     dccm_ready;
   mem_rsp_t dccm_rsp;
   logic     dma_active;

   integer     seed = 58;
   int         cycle_count = 0;
   logic [7:0] dccm_mem [0:`DCCM_SIZE-1];
   logic [7:0] ref_mem  [0:`DCCM_SIZE-1];   // Expected DCCM contents
   ptr_t       rd_tag [$];
   data_t      rd_data [$];
   logic       rd_ecc [$];
   int         rd_wait [$];
   logic       bp_is_wr [BP_CMDS];
   data_t      bp_data [BP_CMDS];
   logic       bp_seen [BP_CMDS];
   int         bp_count;

   dma_ctrl uut (
      .clk           (clk),
      .reset         (reset),
      .aw_valid      (aw_valid),
      .aw            (aw),
      .aw_ready      (aw_ready),
      .w_valid       (w_valid),
      .w             (w),
      .w_ready       (w_ready),
      .ar_valid      (ar_valid),
      .ar            (ar),
      .ar_ready      (ar_ready),
      .b_valid       (b_valid),
      .b             (b),
      .b_ready       (b_ready),
      .r_valid       (r_valid),
      .r             (r),
      .r_ready       (r_ready),
      .dccm_req      (dccm_req),
      .dccm_req_data (dccm_req_data),
      .dccm_ready    (dccm_ready),
      .dccm_rsp      (dccm_rsp),
      .dma_active    (dma_active)
   );

   always #10 clk = ~clk;

   //*************************************************************************
   // Error handling
   //*************************************************************************
   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("Timeout after %0d cycles, a handshake or response never came",
                                 cycle_count));
      end
   end

   //*************************************************************************
   // DCCM model
   //*************************************************************************
   function automatic logic [7:0] fill_byte(input int offs);
      logic [31:0] a;
      a = SADR + offs;
      return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;
   endfunction

   function automatic data_t ref_dword(input addr_t addr);
      data_t d;
      for (int k = 0; k < 8; k++) begin
         d[8*k +: 8] = ref_mem[{addr[15:3], 3'b000} + k];
      end
      return d;
   endfunction

   // Accept requests; writes land at once, reads are queued with a delay
   always @(posedge clk) begin : dccm_accept
      int    lane;
      data_t d;
      if (dccm_req && !dccm_ready) begin
         stop_on_error("DCCM request raised while dccm_ready was low");
      end
      if (dccm_req) begin
         lane = dccm_req_data.addr[2:0];
         if (dccm_req_data.write) begin
            for (int k = 0; k < (1 << dccm_req_data.size); k++) begin
               dccm_mem[dccm_req_data.addr[15:0] + k] = dccm_req_data.wdata[8*(lane+k) +: 8];
            end
         end else begin
            for (int k = 0; k < 8; k++) begin
               d[8*k +: 8] = dccm_mem[{dccm_req_data.addr[15:3], 3'b000} + k];
            end
            rd_tag.push_back(dccm_req_data.tag);
            rd_data.push_back(d);
            rd_ecc.push_back({dccm_req_data.addr[31:3], 3'b000} == ECC_ADDR);
            rd_wait.push_back(1 + (($random(seed) & 32'h7FFF_FFFF) % 3));
         end
      end
   end

   // One read return per cycle, the first that is due
   always @(negedge clk) begin : dccm_return
      int due;
      due = -1;
      dccm_ready = ($random(seed) % 4) != 0;
      for (int i = 0; i < rd_wait.size(); i++) begin
         rd_wait[i] = rd_wait[i] - 1;
         if (rd_wait[i] <= 0 && due < 0) begin
            due = i;
         end
      end
      dccm_rsp = '0;
      if (due >= 0) begin
         dccm_rsp.rvalid    = 1'b1;
         dccm_rsp.ecc_error = rd_ecc[due];
         dccm_rsp.rtag      = rd_tag[due];
         dccm_rsp.rdata     = rd_data[due];
         rd_tag.delete(due);
         rd_data.delete(due);
         rd_ecc.delete(due);
         rd_wait.delete(due);
      end
   end

   //*************************************************************************
   // Master side channel tasks
   //*************************************************************************
   task automatic send_write(input tag_t id, input addr_t addr, input size_t size,
                             input data_t data, input strb_t strb);
      logic aw_done;
      logic w_done;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(negedge clk);
      aw.id    = id;
      aw.addr  = addr;
      aw.size  = size;
      w.data   = data;
      w.strb   = strb;
      aw_valid = 1'b1;
      w_valid  = 1'b1;
      while (!(aw_done && w_done)) begin
         @(posedge clk);
         aw_done = aw_done | (aw_valid & aw_ready);
         w_done  = w_done | (w_valid & w_ready);
         @(negedge clk);
         aw_valid = aw_valid & ~aw_done;
         w_valid  = w_valid & ~w_done;
      end
   endtask

   task automatic send_read(input tag_t id, input addr_t addr, input size_t size);
      @(negedge clk);
      ar.id    = id;
      ar.addr  = addr;
      ar.size  = size;
      ar_valid = 1'b1;
      @(posedge clk);
      while (!ar_ready) @(posedge clk);
      @(negedge clk);
      ar_valid = 1'b0;
   endtask

   // Send a write, wait for B and track the expected memory
   task automatic write_check(input tag_t id, input addr_t addr, input size_t size,
                              input data_t data, input strb_t strb, input resp_t exp_resp);
      send_write(id, addr, size, data, strb);
      @(posedge clk);
      while (!(b_valid && b_ready)) @(posedge clk);
      check_value("bid", b.id, id);
      check_value("bresp", b.resp, exp_resp);
      if (exp_resp == `RESP_OKAY) begin
         for (int k = 0; k < 8; k++) begin
            if (strb[k]) ref_mem[{addr[15:3], 3'b000} + k] = data[8*k +: 8];
         end
      end
   endtask

   // Failed reads carry their address as data
   task automatic read_check(input tag_t id, input addr_t addr, input size_t size,
                             input resp_t exp_resp);
      data_t exp_data;
      exp_data = (exp_resp == `RESP_OKAY) ? ref_dword(addr) : data_t'(addr);
      send_read(id, addr, size);
      @(posedge clk);
      while (!(r_valid && r_ready)) @(posedge clk);
      check_value("rid", r.id, id);
      check_value("rresp", r.resp, exp_resp);
      check_value("rdata", r.data, exp_data);
   endtask

   //*************************************************************************
   // Directed tests
   //*************************************************************************
   task automatic test_round_trip();
      write_check(4'd1, SADR + 32'h10, 3'd3, 64'h0123_4567_89AB_CDEF, 8'hFF, `RESP_OKAY);
      read_check(4'd2, SADR + 32'h10, 3'd3, `RESP_OKAY);
   endtask

   task automatic test_narrow_writes();
      write_check(4'd3, SADR + 32'h40, 3'd3, 64'hA1A2_A3A4_B1B2_B3B4, 8'h0F, `RESP_OKAY);
      write_check(4'd4, SADR + 32'h48, 3'd3, 64'hC1C2_C3C4_D1D2_D3D4, 8'hF0, `RESP_OKAY);
      write_check(4'd5, SADR + 32'h41, 3'd0, 64'h0000_0000_0000_EE00, 8'h02, `RESP_SLVERR);
      write_check(4'd6, SADR + 32'h42, 3'd1, 64'h0000_0000_7788_0000, 8'h0C, `RESP_SLVERR);
      write_check(4'd7, SADR + 32'h4C, 3'd2, 64'h9988_7766_5544_3322, 8'hF0, `RESP_OKAY);
      read_check(4'd8, SADR + 32'h40, 3'd3, `RESP_OKAY);
      read_check(4'd9, SADR + 32'h48, 3'd3, `RESP_OKAY);
   endtask

   task automatic test_decode_error();
      write_check(4'd10, 32'h1000_0000, 3'd3, 64'h1, 8'hFF, `RESP_DECERR);
      read_check(4'd11, 32'h2000_0008, 3'd3, `RESP_DECERR);
      read_check(4'd12, SADR + `DCCM_SIZE, 3'd3, `RESP_DECERR);   // Just past the window
   endtask

   task automatic test_align_error();
      write_check(4'd1, SADR + 32'h22, 3'd2, 64'h5555_6666_7777_8888, 8'h3C, `RESP_SLVERR);
      read_check(4'd2, SADR + 32'h22, 3'd2, `RESP_SLVERR);
      write_check(4'd3, SADR + 32'h28, 3'd3, 64'h1234_5678_9ABC_DEF0, 8'h3C, `RESP_SLVERR);
   endtask

   task automatic test_ecc_error();
      read_check(4'd5, ECC_ADDR, 3'd3, `RESP_SLVERR);
      read_check(4'd6, ECC_ADDR + 32'h8, 3'd3, `RESP_OKAY);
   endtask

   task automatic record_response(input tag_t id, input logic is_write, input resp_t resp,
                                  input data_t data);
      int idx;
      idx = int'(id) - 8;
      if (idx < 0 || idx >= BP_CMDS) begin
         stop_on_error($sformatf("Response with unknown ID %0d", id));
      end
      if (bp_seen[idx]) begin
         stop_on_error($sformatf("ID %0d was answered twice", id));
      end
      bp_seen[idx] = 1'b1;
      bp_count     = bp_count + 1;
      check_value("response is write", is_write, bp_is_wr[idx]);
      check_value("resp", resp, `RESP_OKAY);
      if (!is_write) check_value("rdata", data, bp_data[idx]);
   endtask

   // Fill the buffer and the ingress while responses are held off
   task automatic test_back_pressure();
      addr_t addr;
      @(negedge clk);
      b_ready  = 1'b0;
      r_ready  = 1'b0;
      bp_count = 0;
      for (int i = 0; i < BP_CMDS; i++) begin
         bp_is_wr[i] = (i % 2 == 0);
         bp_seen[i]  = 1'b0;
         if (bp_is_wr[i]) begin
            addr       = SADR + 32'h200 + 8 * i;
            bp_data[i] = {8'(i), 24'hC0FFEE, addr};
            send_write(tag_t'(8 + i), addr, 3'd3, bp_data[i], 8'hFF);
            for (int k = 0; k < 8; k++) ref_mem[addr[15:0] + k] = bp_data[i][8*k +: 8];
         end else begin
            addr       = SADR + 32'h300 + 8 * i;
            bp_data[i] = ref_dword(addr);
            send_read(tag_t'(8 + i), addr, 3'd3);
         end
      end
      @(posedge clk);
      if (aw_ready && w_ready && ar_ready) begin
         stop_on_error("Channel readies stayed high with the command buffer full");
      end
      while (!b_valid) @(posedge clk);
      repeat (5) @(posedge clk);
      if (!b_valid) stop_on_error("A held write response disappeared");
      check_value("held bid", b.id, 4'd8);
      @(negedge clk);
      b_ready = 1'b1;
      r_ready = 1'b1;
      while (bp_count < BP_CMDS) begin
         @(posedge clk);
         if (b_valid && b_ready) record_response(b.id, 1'b1, b.resp, '0);
         if (r_valid && r_ready) record_response(r.id, 1'b0, r.resp, r.data);
      end
      @(negedge clk);
   endtask

   //*************************************************************************
   // Main sequence
   //*************************************************************************
   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      aw_valid   = 1'b0;
      aw         = '0;
      w_valid    = 1'b0;
      w          = '0;
      ar_valid   = 1'b0;
      ar         = '0;
      b_ready    = 1'b1;
      r_ready    = 1'b1;
      dccm_ready = 1'b0;
      dccm_rsp   = '0;
      for (int i = 0; i < `DCCM_SIZE; i++) begin
         dccm_mem[i] = fill_byte(i);
         ref_mem[i]  = fill_byte(i);
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check_value("aw_ready", aw_ready, 1'b1);
      check_value("w_ready", w_ready, 1'b1);
      check_value("ar_ready", ar_ready, 1'b1);
      check_value("b_valid", b_valid, 1'b0);
      check_value("r_valid", r_valid, 1'b0);
      check_value("dccm_req", dccm_req, 1'b0);
      check_value("dma_active", dma_active, 1'b0);
      test_round_trip();
      test_narrow_writes();
      test_decode_error();
      test_align_error();
      test_ecc_error();
      test_back_pressure();
      check_value("final dma_active", dma_active, 1'b0);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire
